// File: include/blimp_cfg.svh
/*
 * Blimp core configuration
 * Widths and depths shared by the RTL and the testbench
 */

`ifndef BLIMP_CFG_SVH
`define BLIMP_CFG_SVH

// Data and instruction word width
`define BLIMP_XLEN 32

// Sequence number width, ROB holds 2^N entries
`define BLIMP_SEQ_BITS 5

// Architectural registers
`define BLIMP_NUM_REGS 32

// Multiplier pipe depth
`define BLIMP_MUL_STAGES 4

`endif

// File: hdl/blimp_pkg.sv
/*
 * Blimp core package
 * Opcode and fetch-state enums, tag types and TinyRV1 encodings
 */

`include "blimp_cfg.svh"

package blimp_pkg;

  // Decoded operation
  typedef enum logic [1:0] {
    OP_ADD     = 2'd0,
    OP_ADDI    = 2'd1,
    OP_MUL     = 2'd2,
    OP_ILLEGAL = 2'd3
  } op_e;

  // Fetch FSM
  typedef enum logic [1:0] {
    F_IDLE = 2'd0,
    F_WAIT = 2'd1,
    F_FULL = 2'd2
  } fetch_state_e;

  // Register index
  typedef logic [4:0] reg_addr_t;

  // ROB slot / program order tag
  typedef logic [`BLIMP_SEQ_BITS-1:0] seq_t;

  // ---------------------------------------------------------------------
  // Instruction encodings

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct7 selects add vs mul under OPC_OP
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_MUL = 7'b0000001;

  // funct3 shared by add, addi and mul
  localparam logic [2:0] F3_ADD = 3'b000;

endpackage

// File: hdl/blimp_intf.sv
/*
 * Blimp internal interfaces
 * Fetch to decode val/rdy link, issue strobes and result strobes
 */

`include "blimp_cfg.svh"

// Fetch to decode, val/rdy with stable payload
interface fetch_decode_if ();
  logic                   val;
  logic                   rdy;
  logic [`BLIMP_XLEN-1:0] pc;
  logic [`BLIMP_XLEN-1:0] inst;

  modport producer (output val, output pc, output inst, input rdy);
  modport consumer (input val, input pc, input inst, output rdy);
endinterface

// Decode to one execute pipe
// Single-cycle strobe, no back-pressure
interface issue_if import blimp_pkg::*; ();
  logic                   val;
  seq_t                   seq;
  op_e                    op;
  logic [`BLIMP_XLEN-1:0] op_a;
  // Immediate for addi
  logic [`BLIMP_XLEN-1:0] op_b;
  reg_addr_t              waddr;
  logic                   wen;

  modport producer (output val, output seq, output op, output op_a,
                    output op_b, output waddr, output wen);
  modport consumer (input val, input seq, input op, input op_a,
                    input op_b, input waddr, input wen);
endinterface

// Result strobe, execute to writeback and writeback to decode
interface result_if import blimp_pkg::*; ();
  logic                   val;
  seq_t                   seq;
  reg_addr_t              waddr;
  logic [`BLIMP_XLEN-1:0] wdata;
  logic                   wen;

  modport producer (output val, output seq, output waddr, output wdata,
                    output wen);
  modport consumer (input val, input seq, input waddr, input wdata,
                    input wen);
endinterface

// File: hdl/fetch_unit.sv
/*
 * Fetch unit
 * Sequential PC, one outstanding memory request and a
 * one-entry instruction buffer presented to decode
 */

`include "blimp_cfg.svh"

module fetch_unit import blimp_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  output logic                   imem_req_val,
  output logic [`BLIMP_XLEN-1:0] imem_req_addr,
  input  logic                   imem_resp_val,
  input  logic [`BLIMP_XLEN-1:0] imem_resp_data,
  fetch_decode_if.producer       out
);

  fetch_state_e           state_q;
  fetch_state_e           state_d;
  logic [`BLIMP_XLEN-1:0] pc_q;
  logic [`BLIMP_XLEN-1:0] buf_pc_q;
  logic [`BLIMP_XLEN-1:0] buf_inst_q;
  logic                   boot_q;
  logic                   accept;

  assign accept = out.val && out.rdy;

  // First request once out of reset, then one per accepted instruction
  assign imem_req_val  = (state_q == F_IDLE && boot_q) || (state_q == F_FULL && accept);
  assign imem_req_addr = pc_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      F_IDLE: if (imem_req_val) state_d = F_WAIT;
      // Memory answers exactly one cycle later
      F_WAIT: if (imem_resp_val) state_d = F_FULL;
      // Next request goes out as decode takes the buffer
      F_FULL: if (accept) state_d = F_WAIT;
      default: state_d = F_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= F_IDLE;
      pc_q    <= '0;
      boot_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      boot_q  <= 1'b1;
      if (imem_req_val) pc_q <= pc_q + `BLIMP_XLEN'(4);
    end
  end

  // Buffer tag follows the request, word follows the response
  always_ff @(posedge clk) begin
    if (imem_req_val) buf_pc_q <= pc_q;
    if (state_q == F_WAIT && imem_resp_val) buf_inst_q <= imem_resp_data;
  end

  assign out.val  = (state_q == F_FULL);
  assign out.pc   = buf_pc_q;
  assign out.inst = buf_inst_q;

endmodule

// File: hdl/decode_issue_unit.sv
/*
 * Decode/issue unit
 * Decodes TinyRV1 add/addi/mul, reads the register file, tracks hazards
 * with a scoreboard and issues in order to the ALU or multiplier pipe
 */

`include "blimp_cfg.svh"

module decode_issue_unit import blimp_pkg::*; (
  input  logic               clk,
  input  logic               arst_n,
  fetch_decode_if.consumer   in,
  issue_if.producer          alu_issue,
  issue_if.producer          mul_issue,
  result_if.consumer         complete,
  input  logic               commit_val
);

  localparam int ROB_DEPTH = 1 << `BLIMP_SEQ_BITS;
  localparam int CNT_W     = `BLIMP_SEQ_BITS + 1;
  localparam int HIST      = `BLIMP_MUL_STAGES - 1;

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  reg_addr_t              rd;
  reg_addr_t              rs1;
  reg_addr_t              rs2;
  op_e                    op;
  logic                   uses_rs2;
  logic                   wen;
  logic [`BLIMP_XLEN-1:0] rs1_data;
  logic [`BLIMP_XLEN-1:0] rs2_data;
  logic [`BLIMP_XLEN-1:0] imm;
  logic [`BLIMP_XLEN-1:0] rf [`BLIMP_NUM_REGS];
  logic [`BLIMP_NUM_REGS-1:0] pending_q;
  seq_t                   seq_q;
  logic [CNT_W-1:0]       inflight_q;
  logic [HIST-1:0]        mul_hist_q;
  logic                   raw_stall;
  logic                   waw_stall;
  logic                   rob_stall;
  logic                   wb_stall;
  logic                   is_mul;
  logic                   fire;

  // ---------------------------------------------------------------------
  // Field extraction and decode

  assign opcode = in.inst[6:0];
  assign rd     = in.inst[11:7];
  assign funct3 = in.inst[14:12];
  assign rs1    = in.inst[19:15];
  assign rs2    = in.inst[24:20];
  assign funct7 = in.inst[31:25];
  assign imm    = {{(`BLIMP_XLEN-12){in.inst[31]}}, in.inst[31:20]};

  always_comb begin
    op = OP_ILLEGAL;
    if (opcode == OPC_OP && funct3 == F3_ADD && funct7 == F7_ADD) op = OP_ADD;
    else if (opcode == OPC_OP && funct3 == F3_ADD && funct7 == F7_MUL) op = OP_MUL;
    else if (opcode == OPC_OP_IMM && funct3 == F3_ADD) op = OP_ADDI;
  end

  assign is_mul   = (op == OP_MUL);
  assign uses_rs2 = (op == OP_ADD) || is_mul;
  // x0 and illegal ops never write
  assign wen      = (op != OP_ILLEGAL) && (rd != '0);

  // x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : rf[rs2];

  // ---------------------------------------------------------------------
  // Stall conditions

  assign raw_stall = ((op != OP_ILLEGAL) && pending_q[rs1]) || (uses_rs2 && pending_q[rs2]);
  assign waw_stall = wen && pending_q[rd];
  assign rob_stall = (inflight_q == CNT_W'(ROB_DEPTH));
  // ALU result would land with a multiply issued HIST cycles back
  assign wb_stall  = !is_mul && mul_hist_q[HIST-1];

  assign in.rdy = in.val && !(raw_stall || waw_stall || rob_stall || wb_stall);
  assign fire   = in.val && in.rdy;

  // Same payload to both pipes, strobe picks one
  assign alu_issue.val   = fire && !is_mul;
  assign alu_issue.seq   = seq_q;
  assign alu_issue.op    = op;
  assign alu_issue.op_a  = rs1_data;
  assign alu_issue.op_b  = (op == OP_ADDI) ? imm : rs2_data;
  assign alu_issue.waddr = rd;
  assign alu_issue.wen   = wen;

  assign mul_issue.val   = fire && is_mul;
  assign mul_issue.seq   = seq_q;
  assign mul_issue.op    = op;
  assign mul_issue.op_a  = rs1_data;
  assign mul_issue.op_b  = rs2_data;
  assign mul_issue.waddr = rd;
  assign mul_issue.wen   = wen;

  // Completed results land in the register file
  always_ff @(posedge clk) begin
    if (complete.val && complete.wen) rf[complete.waddr] <= complete.wdata;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending_q  <= '0;
      seq_q      <= '0;
      inflight_q <= '0;
      mul_hist_q <= '0;
    end else begin
      if (complete.val && complete.wen) pending_q[complete.waddr] <= 1'b0;
      if (fire && wen) pending_q[rd] <= 1'b1;
      if (fire) seq_q <= seq_q + 1'b1;
      inflight_q <= inflight_q + CNT_W'(fire) - CNT_W'(commit_val);
      mul_hist_q <= {mul_hist_q[HIST-2:0], mul_issue.val};
    end
  end

endmodule

// File: hdl/alu_unit.sv
/*
 * ALU pipe
 * One registered adder stage for add, addi and illegal ops
 */

`include "blimp_cfg.svh"

module alu_unit import blimp_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  issue_if.consumer  in,
  result_if.producer out
);

  logic [`BLIMP_XLEN-1:0] sum;

  // op_b already holds the immediate for addi
  always_comb begin
    case (in.op)
      OP_ADD, OP_ADDI: sum = in.op_a + in.op_b;
      default:         sum = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) out.val <= 1'b0;
    else         out.val <= in.val;
  end

  // Tags ride with the result
  always_ff @(posedge clk) begin
    out.seq   <= in.seq;
    out.waddr <= in.waddr;
    out.wen   <= in.wen && (in.op != OP_ILLEGAL);
    out.wdata <= sum;
  end

endmodule

// File: hdl/pipelined_multiplier.sv
/*
 * Pipelined multiplier
 * Low word of op_a * op_b, one byte-wide partial product per stage
 */

`include "blimp_cfg.svh"

module pipelined_multiplier import blimp_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  issue_if.consumer  in,
  result_if.producer out
);

  localparam int STAGES = `BLIMP_MUL_STAGES;
  localparam int CHUNK  = `BLIMP_XLEN / STAGES;

  logic [STAGES-1:0]      val_q;
  logic [STAGES-1:0]      wen_q;
  seq_t                   seq_q   [STAGES];
  reg_addr_t              waddr_q [STAGES];
  logic [`BLIMP_XLEN-1:0] acc_q   [STAGES];
  // Operands only needed up to the second to last stage
  logic [`BLIMP_XLEN-1:0] a_q     [STAGES-1];
  logic [`BLIMP_XLEN-1:0] b_q     [STAGES-1];

  // Partial product of one chunk of b, shifted into place
  function automatic logic [`BLIMP_XLEN-1:0] partial(input logic [`BLIMP_XLEN-1:0] a,
                                                     input logic [`BLIMP_XLEN-1:0] b,
                                                     input int idx);
    logic [CHUNK-1:0] c;
    c = b[idx*CHUNK +: CHUNK];
    return (a * c) << (idx * CHUNK);
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) val_q <= '0;
    else         val_q <= {val_q[STAGES-2:0], in.val && (in.op == OP_MUL)};
  end

  always_ff @(posedge clk) begin
    // Stage 0 takes the lowest chunk
    acc_q[0]   <= partial(in.op_a, in.op_b, 0);
    seq_q[0]   <= in.seq;
    waddr_q[0] <= in.waddr;
    wen_q[0]   <= in.wen;
    a_q[0]     <= in.op_a;
    b_q[0]     <= in.op_b;
    for (int i = 1; i < STAGES; i++) begin
      acc_q[i]   <= acc_q[i-1] + partial(a_q[i-1], b_q[i-1], i);
      seq_q[i]   <= seq_q[i-1];
      waddr_q[i] <= waddr_q[i-1];
      wen_q[i]   <= wen_q[i-1];
    end
    for (int i = 1; i < STAGES - 1; i++) begin
      a_q[i] <= a_q[i-1];
      b_q[i] <= b_q[i-1];
    end
  end

  assign out.val   = val_q[STAGES-1];
  assign out.seq   = seq_q[STAGES-1];
  assign out.waddr = waddr_q[STAGES-1];
  assign out.wen   = wen_q[STAGES-1];
  assign out.wdata = acc_q[STAGES-1];

endmodule

// File: hdl/writeback_commit_unit.sv
/*
 * Writeback/commit unit
 * Forwards completing results to decode, parks them in the ROB
 * and retires in program order onto the trace port
 */

`include "blimp_cfg.svh"

module writeback_commit_unit import blimp_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  result_if.consumer             alu_res,
  result_if.consumer             mul_res,
  result_if.producer             complete,
  output logic                   commit_val,
  output logic                   trace_val,
  output logic [`BLIMP_XLEN-1:0] trace_pc,
  output reg_addr_t              trace_waddr,
  output logic [`BLIMP_XLEN-1:0] trace_wdata,
  output logic                   trace_wen
);

  localparam int ROB_DEPTH = 1 << `BLIMP_SEQ_BITS;

  logic [ROB_DEPTH-1:0]   done_q;
  logic [ROB_DEPTH-1:0]   rob_wen;
  reg_addr_t              rob_waddr [ROB_DEPTH];
  logic [`BLIMP_XLEN-1:0] rob_wdata [ROB_DEPTH];
  seq_t                   head_q;
  logic [`BLIMP_XLEN-3:0] ret_cnt_q;
  logic                   retire;
  logic                   retire_q;

  // ---------------------------------------------------------------------
  // Completion, at most one pipe valid per cycle

  assign complete.val   = alu_res.val || mul_res.val;
  assign complete.seq   = alu_res.val ? alu_res.seq   : mul_res.seq;
  assign complete.waddr = alu_res.val ? alu_res.waddr : mul_res.waddr;
  assign complete.wdata = alu_res.val ? alu_res.wdata : mul_res.wdata;
  assign complete.wen   = alu_res.val ? alu_res.wen   : mul_res.wen;

  // ---------------------------------------------------------------------
  // Reorder buffer and in-order retire

  assign retire = done_q[head_q];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done_q    <= '0;
      head_q    <= '0;
      ret_cnt_q <= '0;
      retire_q  <= 1'b0;
    end else begin
      retire_q <= retire;
      // Completing slot is never the head being retired
      if (complete.val) done_q[complete.seq] <= 1'b1;
      if (retire) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
        ret_cnt_q      <= ret_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (complete.val) begin
      rob_waddr[complete.seq] <= complete.waddr;
      rob_wdata[complete.seq] <= complete.wdata;
      rob_wen[complete.seq]   <= complete.wen;
    end
    // Fetch is strictly sequential from 0, so pc is count * 4
    if (retire) begin
      trace_pc    <= {ret_cnt_q, 2'b00};
      trace_waddr <= rob_waddr[head_q];
      trace_wdata <= rob_wdata[head_q];
      trace_wen   <= rob_wen[head_q];
    end
  end

  assign trace_val  = retire_q;
  assign commit_val = retire_q;

endmodule

// File: hdl/blimp_core.sv
/*
 * Blimp core top level
 * In-order issue, out-of-order completion TinyRV1 arithmetic core
 */

`include "blimp_cfg.svh"

module blimp_core import blimp_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  // Instruction memory
  output logic                   imem_req_val,
  output logic [`BLIMP_XLEN-1:0] imem_req_addr,
  input  logic                   imem_resp_val,
  input  logic [`BLIMP_XLEN-1:0] imem_resp_data,
  // Commit trace
  output logic                   trace_val,
  output logic [`BLIMP_XLEN-1:0] trace_pc,
  output reg_addr_t              trace_waddr,
  output logic [`BLIMP_XLEN-1:0] trace_wdata,
  output logic                   trace_wen
);

  // ---------------------------------------------------------------------
  // Internal links

  fetch_decode_if f2d ();
  issue_if        alu_issue ();
  issue_if        mul_issue ();
  result_if       alu_res ();
  result_if       mul_res ();
  result_if       complete ();
  logic           commit_val;

  // ---------------------------------------------------------------------
  // Units

  fetch_unit fu (
    .clk            (clk),
    .arst_n         (arst_n),
    .imem_req_val   (imem_req_val),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_data (imem_resp_data),
    .out            (f2d)
  );

  decode_issue_unit diu (
    .clk        (clk),
    .arst_n     (arst_n),
    .in         (f2d),
    .alu_issue  (alu_issue),
    .mul_issue  (mul_issue),
    .complete   (complete),
    .commit_val (commit_val)
  );

  alu_unit alu_xu (
    .clk    (clk),
    .arst_n (arst_n),
    .in     (alu_issue),
    .out    (alu_res)
  );

  pipelined_multiplier mul_xu (
    .clk    (clk),
    .arst_n (arst_n),
    .in     (mul_issue),
    .out    (mul_res)
  );

  writeback_commit_unit wcu (
    .clk         (clk),
    .arst_n      (arst_n),
    .alu_res     (alu_res),
    .mul_res     (mul_res),
    .complete    (complete),
    .commit_val  (commit_val),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .trace_wen   (trace_wen)
  );

endmodule

// File: verif/blimp_core_tb.sv
/*
 * Blimp core testbench
 * Random add/addi/mul program, one-cycle memory model and an in-order
 * golden model that checks every commit on the trace port
 */

`include "blimp_cfg.svh"

module blimp_core_tb import blimp_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          PROG_LEN       = 64;
  localparam int          CHAIN_LEN      = 8;
  localparam int          RESET_CYCLES   = 16;
  localparam int          TIMEOUT_CYCLES = RESET_CYCLES + PROG_LEN * 12;
  localparam logic [31:0] LFSR_SEED      = 32'hf69f_df34;
  // addi x0, x0, 0
  localparam logic [31:0] NOP_WORD       = 32'h0000_0013;

  logic                   clk            = 1'b1;
  logic                   arst_n         = 1'b1;
  logic                   imem_req_val;
  logic [`BLIMP_XLEN-1:0] imem_req_addr;
  logic                   imem_resp_val  = 1'b0;
  logic [`BLIMP_XLEN-1:0] imem_resp_data = '0;
  logic                   trace_val;
  logic [`BLIMP_XLEN-1:0] trace_pc;
  reg_addr_t              trace_waddr;
  logic [`BLIMP_XLEN-1:0] trace_wdata;
  logic                   trace_wen;

  logic [31:0] prog      [PROG_LEN];
  logic [4:0]  exp_waddr [PROG_LEN];
  logic        exp_wen   [PROG_LEN];
  logic [31:0] exp_wdata [PROG_LEN];
  logic [31:0] gold_rf   [32];
  logic [31:0] lfsr_q;
  logic        req_pending = 1'b0;
  logic [31:0] req_addr    = '0;
  int          cycle_cnt   = 0;
  int          out_cycles  = 0;
  int          commit_cnt  = 0;
  int          fetch_cnt   = 0;
  int          check_cnt   = 0;
  int          error_cnt   = 0;

  blimp_core uut (
    .clk            (clk),
    .arst_n         (arst_n),
    .imem_req_val   (imem_req_val),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_data (imem_resp_data),
    .trace_val      (trace_val),
    .trace_pc       (trace_pc),
    .trace_waddr    (trace_waddr),
    .trace_wdata    (trace_wdata),
    .trace_wen      (trace_wen)
  );

  // ---------------------------------------------------------------------
  // Random source on x^32 + x^22 + x^2 + x + 1

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] draw(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < nbits; k++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // ---------------------------------------------------------------------
  // Program build and golden execution in program order

  task automatic place(input int idx, input op_e op, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [4:0] rs2,
                       input logic [11:0] imm);
    logic [31:0] word;
    logic [31:0] res;
    case (op)
      OP_ADD: begin
        word = {F7_ADD, rs2, rs1, F3_ADD, rd, OPC_OP};
        res  = gold_rf[rs1] + gold_rf[rs2];
      end
      OP_ADDI: begin
        word = {imm, rs1, F3_ADD, rd, OPC_OP_IMM};
        res  = gold_rf[rs1] + {{20{imm[11]}}, imm};
      end
      OP_MUL: begin
        // Low word only so products wrap
        word = {F7_MUL, rs2, rs1, F3_ADD, rd, OPC_OP};
        res  = gold_rf[rs1] * gold_rf[rs2];
      end
      default: begin
        // Unused major opcode
        word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b1111111};
        res  = '0;
      end
    endcase
    prog[idx]      = word;
    exp_waddr[idx] = rd;
    exp_wen[idx]   = (op != OP_ILLEGAL) && (rd != 5'd0);
    exp_wdata[idx] = res;
    if (exp_wen[idx])
      gold_rf[rd] = res;
  endtask

  task automatic build_program();
    logic [2:0] sel;
    op_e        op;
    for (int r = 0; r < 32; r++)
      gold_rf[r] = '0;
    // Dependent chain where each add waits on the mul before it
    place(0, OP_ADDI, 5'd1, 5'd0, 5'd0, 12'd3);
    place(1, OP_ADDI, 5'd2, 5'd0, 5'd0, 12'hff9);
    place(2, OP_MUL,  5'd3, 5'd1, 5'd2, 12'd0);
    place(3, OP_ADD,  5'd4, 5'd3, 5'd1, 12'd0);
    place(4, OP_MUL,  5'd5, 5'd4, 5'd2, 12'd0);
    place(5, OP_ADD,  5'd5, 5'd5, 5'd3, 12'd0);
    place(6, OP_MUL,  5'd6, 5'd5, 5'd5, 12'd0);
    place(7, OP_ADD,  5'd7, 5'd6, 5'd5, 12'd0);
    // Random tail on x0..x7 with mul weighted up
    for (int i = CHAIN_LEN; i < PROG_LEN; i++) begin
      sel = 3'(draw(3));
      case (sel)
        3'd0, 3'd1: op = OP_ADD;
        3'd2, 3'd3: op = OP_ADDI;
        3'd7:       op = OP_ILLEGAL;
        default:    op = OP_MUL;
      endcase
      place(i, op, 5'(draw(3)), 5'(draw(3)), 5'(draw(3)), 12'(draw(12)));
    end
  endtask

  // ---------------------------------------------------------------------
  // Checks

  task automatic check_value(input string name, input int idx,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_cnt++;
    assert (actual === expected) else begin
      error_cnt++;
      $display("** Error %s[%0d]: expected %h, actual %h", name, idx, expected, actual);
    end
  endtask

  task automatic check_commit(input int n);
    string prefix;
    prefix = (n < CHAIN_LEN) ? "chain" : "program";
    check_value({prefix, "_pc"}, n, n * 4, trace_pc);
    check_value({prefix, "_waddr"}, n, {27'b0, exp_waddr[n]}, {27'b0, trace_waddr});
    check_value({prefix, "_wen"}, n, {31'b0, exp_wen[n]}, {31'b0, trace_wen});
    // Data is only defined for real writes
    if (exp_wen[n])
      check_value({prefix, "_wdata"}, n, exp_wdata[n], trace_wdata);
  endtask

  // Rising edge sees the state settled during the previous cycle
  always @(posedge clk) begin
    cycle_cnt++;
    if (out_cycles == 0) begin
      check_value("reset_req_val", cycle_cnt, 32'd0, {31'b0, imem_req_val});
      check_value("reset_trace_val", cycle_cnt, 32'd0, {31'b0, trace_val});
    end
    if (arst_n)
      out_cycles++;
    // Requests walk memory one word at a time from address 0
    if (arst_n && imem_req_val === 1'b1) begin
      check_value("fetch_addr", fetch_cnt, fetch_cnt * 4, imem_req_addr);
      fetch_cnt++;
    end
    if (arst_n && trace_val === 1'b1) begin
      if (commit_cnt < PROG_LEN)
        check_commit(commit_cnt);
      commit_cnt++;
    end
  end

  // ---------------------------------------------------------------------
  // Memory model answering one cycle after each request

  always @(negedge clk) begin
    imem_resp_val  = req_pending;
    imem_resp_data = NOP_WORD;
    if (req_pending && req_addr[31:2] < PROG_LEN)
      imem_resp_data = prog[req_addr[31:2]];
    req_pending = (imem_req_val === 1'b1);
    req_addr    = imem_req_addr;
  end

  initial begin
    forever #50 clk = ~clk;
  end

  initial begin
    lfsr_q = LFSR_SEED;
    build_program();
    @(negedge clk);
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    while (commit_cnt < PROG_LEN && cycle_cnt < TIMEOUT_CYCLES)
      @(negedge clk);
    if (commit_cnt < PROG_LEN) begin
      error_cnt++;
      $display("Timeout after %0d cycles, commits missing: only %0d of %0d retired",
               cycle_cnt, commit_cnt, PROG_LEN);
    end
    $display("Checks: %0d, errors: %0d, commits: %0d of %0d",
             check_cnt, error_cnt, commit_cnt, PROG_LEN);
    if (error_cnt == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: blimp_core.f
+incdir+include
hdl/blimp_pkg.sv
hdl/blimp_intf.sv
hdl/fetch_unit.sv
hdl/decode_issue_unit.sv
hdl/alu_unit.sv
hdl/pipelined_multiplier.sv
hdl/writeback_commit_unit.sv
hdl/blimp_core.sv
verif/blimp_core_tb.sv
